// ==== tb.f ====
design/udp_rx_pkg.sv
design/rx_payload_if.sv
design/frame_check_sequence.sv
design/frame_byte_counter.sv
design/frame_parser_fsm.sv
design/payload_fifo.sv
design/udp_receive_handler.sv
design/udp_rx_port.sv
tb/tb_udp_rx_port.sv

// ==== tb/tb_udp_rx_port.sv ====
/*
  Testbench for the UDP receive port. Frames carry their own CRC-32 and
  are sent only while receive_data_ready is high. Output words are
  compared by assertions against the expected payload queue.
*/
`timescale 1ns/10ps

module tb_udp_rx_port;

    localparam logic [15:0] LISTEN_PORT  = 16'h1234;
    localparam int          FRAME_EXTRA  = 46;   // Header plus FCS
    localparam int          FRAME_COUNT  = 9;
    localparam int          PAYLOAD_SUM  = 160;
    localparam int          OUTPUT_WORDS = 126;
    localparam int          CYCLE_LIMIT  =
        3 * (FRAME_COUNT * FRAME_EXTRA + PAYLOAD_SUM + OUTPUT_WORDS) + 200;

    logic                    clock;
    logic                    rst_n;
    udp_rx_pkg::frame_word_t receive_data;
    logic                    receive_data_enable;
    logic                    transmit_data_enable;
    logic                    receive_data_ready;
    udp_rx_pkg::frame_word_t transmit_data;
    logic                    transmit_data_valid;

    logic [7:0]  frame_bytes [0:255];
    int          frame_len;
    logic [8:0]  expected_mem [0:255];   // Never wraps, total payload is small
    int          head_index = 0;
    int          tail_index = 0;
    logic [8:0]  expected_head;
    logic [15:0] payload_lfsr;
    logic [15:0] enable_lfsr;
    logic        random_enable = 1'b0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          test_number = 0;
    int          failed_tests = 0;
    int          test_errors_start;

    udp_rx_port #(.LISTEN_PORT(LISTEN_PORT), .FIFO_DEPTH(2048)) i_udp_rx_port (
        .clock                (clock),
        .rst_n                (rst_n),
        .receive_data         (receive_data),
        .receive_data_enable  (receive_data_enable),
        .transmit_data_enable (transmit_data_enable),
        .receive_data_ready   (receive_data_ready),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard
    assign expected_head = expected_mem[head_index];

    always @(posedge clock) begin
        if (transmit_data_valid && head_index != tail_index) begin
            head_index <= head_index + 1;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        transmit_data_valid |-> head_index != tail_index)
        else begin
            error_count++;
            $display("unexpected output word 0x%03h while no payload was pending",
                     $sampled(transmit_data));
        end

    assert property (@(posedge clock) disable iff (!rst_n)
        transmit_data_valid && head_index != tail_index |-> transmit_data == expected_head)
        else begin
            error_count++;
            $display("MISMATCH transmit_data got 0x%03h expected 0x%03h",
                     $sampled(transmit_data), $sampled(expected_head));
        end

    assert property (@(posedge clock) disable iff (!rst_n)
        transmit_data_valid |-> transmit_data_enable)
        else begin
            error_count++;
            $display("transmit_data_valid was high while transmit_data_enable was low");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        int         k;
        value = 8'h00;
        for (k = 0; k < 8; k++) begin
            payload_lfsr = lfsr_next(payload_lfsr);
            value = {value[6:0], payload_lfsr[0]};
        end
        return value;
    endfunction

    // Bit-serial reflected CRC-32
    function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] value);
        logic feedback;
        int   k;
        for (k = 0; k < 8; k++) begin
            feedback = crc[0] ^ value[k];
            crc = crc >> 1;
            if (feedback) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
        return crc;
    endfunction

    always @(negedge clock) begin
        if (random_enable) begin
            enable_lfsr = lfsr_next(enable_lfsr);
            transmit_data_enable <= enable_lfsr[0];
        end else begin
            transmit_data_enable <= 1'b1;
        end
    end

    task automatic build_frame(input int payload_len, input logic [15:0] ethertype,
                               input logic [7:0] protocol, input logic [15:0] dest_port,
                               input logic corrupt_fcs);
        int          i;
        logic        good;
        logic [31:0] crc;
        good = (ethertype == 16'h0800) && (protocol == 8'd17) && (dest_port == LISTEN_PORT) &&
               !corrupt_fcs && (payload_len > 0);
        for (i = 0; i < 42; i++) begin
            frame_bytes[i] = 8'h00;
        end
        frame_bytes[0]  = 8'h02;             // Local MAC addresses
        frame_bytes[5]  = 8'h01;
        frame_bytes[6]  = 8'h02;
        frame_bytes[11] = 8'h02;
        {frame_bytes[12], frame_bytes[13]} = ethertype;
        frame_bytes[14] = 8'h45;
        {frame_bytes[16], frame_bytes[17]} = 16'(28 + payload_len);
        frame_bytes[22] = 8'h40;
        frame_bytes[23] = protocol;
        {frame_bytes[36], frame_bytes[37]} = dest_port;
        {frame_bytes[38], frame_bytes[39]} = 16'(8 + payload_len);
        for (i = 0; i < payload_len; i++) begin
            frame_bytes[42 + i] = random_byte();
            if (good) begin
                expected_mem[tail_index] = {(i == payload_len - 1), frame_bytes[42 + i]};
                tail_index++;
            end
        end
        crc = 32'hFFFF_FFFF;
        for (i = 0; i < 42 + payload_len; i++) begin
            crc = crc_add_byte(crc, frame_bytes[i]);
        end
        crc = ~crc;
        frame_len = 46 + payload_len;
        for (i = 0; i < 4; i++) begin
            frame_bytes[42 + payload_len + i] = crc[8*i +: 8];   // LSB first
        end
        if (corrupt_fcs) begin
            frame_bytes[frame_len - 2] = frame_bytes[frame_len - 2] ^ 8'h10;
        end
    endtask

    // Caller sits on a falling edge; returns once the port is ready again
    task automatic send_frame(input logic with_gaps);
        int i;
        while (!receive_data_ready)
            @(negedge clock);
        for (i = 0; i < frame_len; i++) begin
            if (with_gaps && i > 0) begin
                payload_lfsr = lfsr_next(payload_lfsr);
                if (payload_lfsr[0]) begin
                    receive_data_enable = 1'b0;
                    @(negedge clock);
                end
            end
            receive_data = '{last: (i == frame_len - 1), data: frame_bytes[i]};
            receive_data_enable = 1'b1;
            @(negedge clock);
        end
        receive_data_enable = 1'b0;
        while (!receive_data_ready)
            @(negedge clock);
    endtask

    task automatic start_test();
        test_number++;
        test_errors_start = error_count;
    endtask

    task automatic finish_test(input string name);
        assert (head_index == tail_index)
            else begin
                error_count++;
                $display("%0d expected payload words were never delivered",
                         tail_index - head_index);
            end
        if (error_count == test_errors_start) begin
            $display("test %0d %s: ok", test_number, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_number, name,
                     error_count - test_errors_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        rst_n                = 1'b0;
        receive_data         = '0;
        receive_data_enable  = 1'b0;
        transmit_data_enable = 1'b0;
        payload_lfsr         = 16'd61;
        enable_lfsr          = 16'd61;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        start_test();
        assert (!transmit_data_valid && receive_data_ready)
            else begin
                error_count++;
                $display("after reset the port is not idle and ready");
            end
        build_frame(10, 16'h0800, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b0);
        finish_test("good frame after reset");

        start_test();
        build_frame(10, 16'h0800, 8'd17, LISTEN_PORT, 1'b1);
        send_frame(1'b0);
        build_frame(20, 16'h0800, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b0);
        finish_test("bad FCS then good frame");

        start_test();
        build_frame(8, 16'h86DD, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b0);
        build_frame(8, 16'h0800, 8'd6, LISTEN_PORT, 1'b0);   // TCP
        send_frame(1'b0);
        build_frame(8, 16'h0800, 8'd17, 16'h1235, 1'b0);
        send_frame(1'b0);
        finish_test("wrong header fields");

        start_test();
        build_frame(0, 16'h0800, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b0);
        finish_test("runt frame");

        start_test();
        random_enable <= 1'b1;
        build_frame(64, 16'h0800, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b0);
        random_enable <= 1'b0;
        finish_test("random back-pressure");

        start_test();
        build_frame(32, 16'h0800, 8'd17, LISTEN_PORT, 1'b0);
        send_frame(1'b1);
        finish_test("gaps in receive strobe");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_number, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/udp_rx_port.sv ====
/*
  Receive side of the virtual UDP port, single receive slot.
  A frame may only start while receive_data_ready is high.
*/
`timescale 1ns/10ps

module udp_rx_port #(
    parameter logic [15:0] LISTEN_PORT = 16'h1234,
    parameter int          FIFO_DEPTH  = 2048
)(
    input  logic                    clock,
    input  logic                    rst_n,
    input  udp_rx_pkg::frame_word_t receive_data,
    input  logic                    receive_data_enable,
    input  logic                    transmit_data_enable,
    output logic                    receive_data_ready,
    output udp_rx_pkg::frame_word_t transmit_data,
    output logic                    transmit_data_valid
);

    logic good_packet;
    logic bad_packet;

    rx_payload_if payload_bus ();

    frame_parser_fsm #(.LISTEN_PORT(LISTEN_PORT)) i_frame_parser_fsm (
        .clock               (clock),
        .rst_n               (rst_n),
        .receive_data        (receive_data),
        .receive_data_enable (receive_data_enable),
        .receive_data_ready  (receive_data_ready),
        .payload             (payload_bus),
        .good_packet         (good_packet),
        .bad_packet          (bad_packet)
    );

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_payload_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .port  (payload_bus)
    );

    udp_receive_handler i_udp_receive_handler (
        .clock                (clock),
        .rst_n                (rst_n),
        .good_packet          (good_packet),
        .bad_packet           (bad_packet),
        .transmit_data_enable (transmit_data_enable),
        .payload              (payload_bus),
        .transmit_data        (transmit_data),
        .transmit_data_valid  (transmit_data_valid)
    );

endmodule

// ==== design/udp_receive_handler.sv ====
/*
  Drains a good payload under transmit_data_enable, flushes a bad one.
  Only one frame is ever held in the FIFO.
*/
`timescale 1ns/10ps

module udp_receive_handler (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    good_packet,
    input  logic                    bad_packet,
    input  logic                    transmit_data_enable,
    rx_payload_if.reader            payload,
    output udp_rx_pkg::frame_word_t transmit_data,
    output logic                    transmit_data_valid
);

    logic forwarding;
    logic pop;
    logic flush_pulse;

    assign pop = forwarding && transmit_data_enable && !payload.empty;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            forwarding <= 1'b0;
        end else if (good_packet) begin
            forwarding <= 1'b1;
        end else if (pop && payload.read_word.last) begin
            forwarding <= 1'b0;                 // Final payload byte gone
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            flush_pulse <= 1'b0;
        end else begin
            flush_pulse <= bad_packet;
        end
    end

    assign payload.read_enable = pop;
    assign payload.flush       = flush_pulse;

    // Word is consumed in the cycle it is shown
    assign transmit_data       = payload.read_word;
    assign transmit_data_valid = pop;

    assert property (@(posedge clock) disable iff (!rst_n) good_packet |-> !forwarding)
        else $error("udp_receive_handler: good_packet while forwarding");

endmodule

// ==== design/payload_fifo.sv ====
/*
  Synchronous first-word-fall-through FIFO for payload words.
  FIFO_DEPTH must be a power of two. flush takes priority over all access.
*/
`timescale 1ns/10ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 2048
)(
    input  logic      clock,
    input  logic      rst_n,
    rx_payload_if.fifo port
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    udp_rx_pkg::frame_word_t mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]       write_ptr;
    logic [ADDR_W-1:0]       read_ptr;
    logic [ADDR_W:0]         fill;
    logic                    do_write;
    logic                    do_read;

    assign do_write = port.write_enable && !port.full;
    assign do_read  = port.read_enable && !port.empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[write_ptr] <= port.write_word;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            fill      <= '0;
        end else if (port.flush) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            fill      <= '0;
        end else begin
            if (do_write) write_ptr <= write_ptr + 1'b1;
            if (do_read)  read_ptr  <= read_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign port.read_word = mem[read_ptr];   // Head shows while not empty
    assign port.empty     = (fill == '0);
    assign port.full      = (fill == (ADDR_W + 1)'(FIFO_DEPTH));

    ////////////////////////////////////////////////////////////////////////////
    // Parser and handler must respect the flags
    assert property (@(posedge clock) disable iff (!rst_n) port.write_enable |-> !port.full)
        else $error("payload_fifo: write while full");

    assert property (@(posedge clock) disable iff (!rst_n) port.read_enable |-> !port.empty)
        else $error("payload_fifo: read while empty");

endmodule

// ==== design/frame_parser_fsm.sv ====
/*
  Receive FSM. A frame may only start while receive_data_ready is high.
  Payload bytes are held back FCS_BYTES deep so the FCS never reaches
  the FIFO. Verdict pulses one cycle after the last byte.
*/
`timescale 1ns/10ps

module frame_parser_fsm #(
    parameter logic [15:0] LISTEN_PORT = 16'h1234
)(
    input  logic                    clock,
    input  logic                    rst_n,
    input  udp_rx_pkg::frame_word_t receive_data,
    input  logic                    receive_data_enable,
    output logic                    receive_data_ready,
    rx_payload_if.writer            payload,
    output logic                    good_packet,
    output logic                    bad_packet
);

    localparam int DELAY_W = udp_rx_pkg::FCS_BYTES * 8;

    udp_rx_pkg::rx_state_t          state;
    udp_rx_pkg::rx_state_t          state_next;
    logic [udp_rx_pkg::COUNT_W-1:0] count;
    logic                           at_ethertype;
    logic                           at_protocol;
    logic                           at_udp_port;
    logic                           in_payload;
    logic                           take;
    logic                           frame_clear;
    logic                           crc_match;
    logic                           frame_ok;
    logic                           field_bad;
    logic                           write_due;
    logic                           overflow;
    logic [7:0]                     expected;
    logic [DELAY_W-1:0]             delay_line;

    frame_byte_counter i_frame_byte_counter (
        .clock        (clock),
        .rst_n        (rst_n),
        .clear        (frame_clear),
        .count_enable (take),
        .count        (count),
        .at_ethertype (at_ethertype),
        .at_protocol  (at_protocol),
        .at_udp_port  (at_udp_port),
        .in_payload   (in_payload)
    );

    frame_check_sequence i_frame_check_sequence (
        .clock       (clock),
        .rst_n       (rst_n),
        .clear       (frame_clear),
        .data        (receive_data.data),
        .data_enable (take),
        .match       (crc_match)
    );

    assign receive_data_ready = (state == udp_rx_pkg::IDLE) && payload.empty;
    assign take = receive_data_enable && (receive_data_ready ||
                  state == udp_rx_pkg::RECEIVE || state == udp_rx_pkg::DISCARD);
    assign frame_clear = (state == udp_rx_pkg::VERDICT);

    ////////////////////////////////////////////////////////////////////////////
    // Header field checks
    always_comb begin
        expected = receive_data.data;   // No check outside the fields
        if (at_ethertype) begin
            expected = (count == udp_rx_pkg::ETHERTYPE_OFFSET) ?
                       udp_rx_pkg::ETHERTYPE_IPV4[15:8] : udp_rx_pkg::ETHERTYPE_IPV4[7:0];
        end else if (at_protocol) begin
            expected = udp_rx_pkg::IP_PROTOCOL_UDP;
        end else if (at_udp_port) begin
            expected = (count == udp_rx_pkg::UDP_DEST_OFFSET) ? LISTEN_PORT[15:8] : LISTEN_PORT[7:0];
        end
    end

    assign field_bad = take && (state == udp_rx_pkg::RECEIVE) && (receive_data.data != expected);

    ////////////////////////////////////////////////////////////////////////////
    // FCS delay line and FIFO write
    assign write_due = take && (state == udp_rx_pkg::RECEIVE) && in_payload &&
                       (count >= udp_rx_pkg::HEADER_BYTES + udp_rx_pkg::FCS_BYTES);
    assign overflow  = write_due && payload.full;

    assign payload.write_enable = write_due && !payload.full;
    assign payload.write_word   = '{last: receive_data.last, data: delay_line[DELAY_W-1 -: 8]};

    always_ff @(posedge clock) begin
        if (take && in_payload) begin
            delay_line <= {delay_line[DELAY_W-9:0], receive_data.data};
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            frame_ok <= 1'b1;
        end else if (frame_clear) begin
            frame_ok <= 1'b1;
        end else if (field_bad || overflow) begin
            frame_ok <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    always_comb begin
        state_next = state;
        case (state)
            udp_rx_pkg::IDLE: begin
                if (take) begin
                    state_next = receive_data.last ? udp_rx_pkg::VERDICT : udp_rx_pkg::RECEIVE;
                end
            end
            udp_rx_pkg::RECEIVE: begin
                if (take && receive_data.last) begin
                    state_next = udp_rx_pkg::VERDICT;
                end else if (field_bad || overflow) begin
                    state_next = udp_rx_pkg::DISCARD;
                end
            end
            udp_rx_pkg::DISCARD: begin
                if (take && receive_data.last) begin
                    state_next = udp_rx_pkg::VERDICT;
                end
            end
            default: state_next = udp_rx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= udp_rx_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Runts without payload fail the length test
    assign good_packet = frame_clear && frame_ok && crc_match &&
                         (count > udp_rx_pkg::HEADER_BYTES + udp_rx_pkg::FCS_BYTES);
    assign bad_packet  = frame_clear && !good_packet;

    // Last payload word was written in the cycle of the last byte
    assert property (@(posedge clock) disable iff (!rst_n) good_packet |-> !payload.empty)
        else $error("frame_parser_fsm: good verdict with an empty payload FIFO");

endmodule

// ==== design/frame_byte_counter.sv ====
/*
  Counts frame bytes, saturating at the top of COUNT_W.
  Position flags refer to the byte presented in the current cycle.
*/
`timescale 1ns/10ps

module frame_byte_counter (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           count_enable,
    output logic [udp_rx_pkg::COUNT_W-1:0] count,
    output logic                           at_ethertype,
    output logic                           at_protocol,
    output logic                           at_udp_port,
    output logic                           in_payload
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_enable && count != '1) begin
            count <= count + 1'b1;
        end
    end

    assign at_ethertype = (count == udp_rx_pkg::ETHERTYPE_OFFSET) ||
                          (count == udp_rx_pkg::ETHERTYPE_OFFSET + 1'b1);
    assign at_protocol  = (count == udp_rx_pkg::IP_PROTOCOL_OFFSET);
    assign at_udp_port  = (count == udp_rx_pkg::UDP_DEST_OFFSET) ||
                          (count == udp_rx_pkg::UDP_DEST_OFFSET + 1'b1);
    assign in_payload   = (count >= udp_rx_pkg::HEADER_BYTES);

endmodule

// ==== design/frame_check_sequence.sv ====
/*
  Byte-serial Ethernet CRC-32, LSB first.
  match is only meaningful after the FCS bytes have been fed in.
*/
`timescale 1ns/10ps

module frame_check_sequence (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       clear,
    input  logic [7:0] data,
    input  logic       data_enable,
    output logic       match
);

    logic [31:0] crc;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] byte_in);
        logic [31:0] c;
        int          bit_index;
        c = crc_in ^ {24'd0, byte_in};
        for (bit_index = 0; bit_index < 8; bit_index++) begin
            c = c[0] ? ((c >> 1) ^ udp_rx_pkg::CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1;                      // Preset for next frame
        end else if (data_enable) begin
            crc <= crc_byte(crc, data);
        end
    end

    assign match = (crc == udp_rx_pkg::CRC_RESIDUE);

endmodule

// ==== design/rx_payload_if.sv ====
/*
  Payload path between parser, payload FIFO and receive handler.
  The FIFO is first-word-fall-through, one read_enable pops one word.
*/
`timescale 1ns/10ps

interface rx_payload_if;

    udp_rx_pkg::frame_word_t write_word;
    logic                    write_enable;
    udp_rx_pkg::frame_word_t read_word;
    logic                    read_enable;
    logic                    empty;
    logic                    full;
    logic                    flush;     // Drops all stored words in one cycle

    modport writer (
        output write_word, write_enable,
        input  full, empty
    );

    modport reader (
        output read_enable, flush,
        input  read_word, empty
    );

    modport fifo (
        input  write_word, write_enable, read_enable, flush,
        output read_word, empty, full
    );

endinterface

// ==== design/udp_rx_pkg.sv ====
/*
  Shared types and constants of the UDP receive path.
  Offsets assume an untagged Ethernet II frame without preamble
  and a 20-byte IPv4 header without options.
*/
package udp_rx_pkg;

    localparam int COUNT_W = 16;

    // One word on the byte stream and in the payload FIFO
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } frame_word_t;

    typedef enum logic [1:0] {
        IDLE,
        RECEIVE,
        DISCARD,
        VERDICT
    } rx_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Byte positions, counted from the first destination MAC byte
    localparam logic [COUNT_W-1:0] ETHERTYPE_OFFSET   = COUNT_W'(12);
    localparam logic [COUNT_W-1:0] IP_PROTOCOL_OFFSET = COUNT_W'(23);
    localparam logic [COUNT_W-1:0] UDP_DEST_OFFSET    = COUNT_W'(36);
    localparam logic [COUNT_W-1:0] HEADER_BYTES       = COUNT_W'(42); // First payload byte
    localparam logic [COUNT_W-1:0] FCS_BYTES          = COUNT_W'(4);

    ////////////////////////////////////////////////////////////////////////////
    // Protocol values
    localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  IP_PROTOCOL_UDP = 8'd17;

    // Reflected CRC-32, residue taken before the final inversion
    localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

endpackage
